/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = eth_tx_dma_tb
FLIST     = flist.f
PASS_MSG  = Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

/* dv/eth_tx_dma_sva.sv */
`timescale 1ns/1ps

module eth_tx_dma_sva
   import eth_dma_pkg::*;
(
   input logic      clk_i,
   input logic      arst_i,
   input logic      axi_arvalid_o,
   input logic      axi_arready_i,
   input axi_addr_t axi_araddr_o,
   input axi_len_t  axi_arlen_o,
   input logic      bd_wen_o,
   input logic      send_o
);

   // Address request held until accepted
   ar_hold_a: assert property (@(posedge clk_i) disable iff (arst_i)
      axi_arvalid_o && !axi_arready_i |=> axi_arvalid_o && $stable(axi_araddr_o))
      else $error("arvalid dropped or araddr changed before arready");

   ar_len_a: assert property (@(posedge clk_i) disable iff (arst_i)
      axi_arvalid_o |-> axi_arlen_o <= axi_len_t'(AXI_MAX_BURST_LEN - 1))
      else $error("arlen above the burst limit");

   // Status write is a single cycle
   bd_wen_pulse_a: assert property (@(posedge clk_i) disable iff (arst_i)
      bd_wen_o |=> !bd_wen_o)
      else $error("bd_wen_o held longer than one cycle");

   send_wen_a: assert property (@(posedge clk_i) disable iff (arst_i)
      !(send_o && bd_wen_o))
      else $error("send_o high during status write");

endmodule

/* dv/eth_tx_dma_tb.sv */
`timescale 1ns/1ps

module eth_tx_dma_tb
   import eth_dma_pkg::*;
();

   localparam int MAX_FRAMES = 16;
   localparam int COLS       = 7;

   // Pattern file columns
   localparam int C_IDX  = 0;
   localparam int C_LEN  = 1;
   localparam int C_PTR  = 2;
   localparam int C_IRQ  = 3;
   localparam int C_WRAP = 4;
   localparam int C_CRC  = 5;
   localparam int C_EXP  = 6;

   logic       clk_i         = 1'b0;
   logic       arst_i        = 1'b1;
   logic       tx_en_i       = 1'b0;
   bd_num_t    tx_bd_num_i   = 7'd5;
   bd_word_t   bd_rdata_i    = '0;
   logic       axi_arready_i = 1'b0;
   axi_data_t  axi_rdata_i   = '0;
   logic       axi_rvalid_i  = 1'b0;
   logic       axi_rlast_i   = 1'b0;
   logic       tx_ready_i    = 1'b1;

   bd_addr_t   bd_raddr_o;
   logic       bd_wen_o;
   bd_addr_t   bd_waddr_o;
   bd_word_t   bd_wdata_o;
   axi_addr_t  axi_araddr_o;
   axi_len_t   axi_arlen_o;
   logic       axi_arvalid_o;
   logic       axi_rready_o;
   logic       fb_wen_o;
   fb_addr_t   fb_addr_o;
   byte_t      fb_wdata_o;
   logic       send_o;
   frame_len_t tx_nbytes_o;
   logic       crc_en_o;
   logic       tx_irq_o;

   // Memory models
   byte_t       ext_mem [0:65535];
   byte_t       fb_mem  [0:2047] = '{default: '0};
   bd_word_t    bd_mem  [0:255]  = '{default: '0};
   logic [31:0] pat     [0:127];

   int        nframes;
   int        limit;
   int        cycles      = 0;
   int        cur         = 0;
   int        frames_done = 0;
   int        done_bytes  = 0;
   int        wb_applied  = 0;
   int        armed       = 0;
   int        arm_delay   = 0;
   int        tx_delay    = 3;
   int        tx_released = 0;
   int        beats_left  = 0;
   logic      busy        = 1'b0;
   logic      hold_phase  = 1'b1;
   axi_addr_t burst_addr  = '0;
   bd_addr_t  bd_rd_addr  = '0;
   bd_addr_t  wr_addr     = '0;
   bd_word_t  wr_data     = '0;

   eth_tx_dma eth_tx_dma_inst (.*);

   bind eth_tx_dma eth_tx_dma_sva eth_tx_dma_sva_inst (.*);

   always #20 clk_i = ~clk_i;

   function automatic logic [31:0] fld(int line, int col);
      return pat[7'(line * COLS + col)];
   endfunction

   function automatic frame_len_t line_len(int line);
      return frame_len_t'(fld(line, C_LEN));
   endfunction

   function automatic axi_addr_t line_ptr(int line);
      return axi_addr_t'(fld(line, C_PTR));
   endfunction

   // Descriptor status word built from the field layout
   function automatic bd_word_t line_desc(int line, logic ready);
      bd_word_t w;
      w = '0;
      w[BD_LEN_LSB +: 11] = line_len(line);
      w[BD_READY_BIT]     = ready;
      w[BD_IRQ_BIT]       = fld(line, C_IRQ) != 0;
      w[BD_WRAP_BIT]      = fld(line, C_WRAP) != 0;
      w[BD_CRC_BIT]       = fld(line, C_CRC) != 0;
      return w;
   endfunction

   task automatic report_failure();
      $display("Something failed");
      $fatal(1, "Run stopped at %0t", $time);
   endtask

   task automatic value_error(string what, logic [31:0] act, logic [31:0] exp);
      $display("ERR %0t: %s is %h, expected %h", $time, what, act, exp);
      report_failure();
   endtask

   task automatic compare_byte(byte_t act, byte_t exp, string what);
      if (act !== exp)
         value_error(what, 32'(act), 32'(exp));
   endtask

   task automatic compare_word(bd_word_t act, bd_word_t exp, string what);
      if (act !== exp)
         value_error(what, act, exp);
   endtask

   task automatic compare_len(frame_len_t act, frame_len_t exp, string what);
      if (act !== exp)
         value_error(what, 32'(act), 32'(exp));
   endtask

   task automatic compare_addr(axi_addr_t act, axi_addr_t exp, string what);
      if (act !== exp)
         value_error(what, act, exp);
   endtask

   task automatic compare_bit(logic act, logic exp, string what);
      if (act !== exp)
         value_error(what, 32'(act), 32'(exp));
   endtask

   // Read address is registered, data follows one cycle later
   always @(posedge clk_i)
      bd_rd_addr = bd_raddr_o;

   // Descriptor memory: status write, arming of the next line, read port
   always @(negedge clk_i) begin
      if (wb_applied != frames_done) begin
         bd_mem[wr_addr] = wr_data;
         wb_applied      = frames_done;
      end
      // Next descriptor handed to DMA after a random delay, so it gets polled first
      if (armed < nframes && armed == frames_done) begin
         if (arm_delay == 0) begin
            bd_mem[bd_addr_t'(2 * fld(armed, C_IDX))]     = line_desc(armed, 1'b1);
            bd_mem[bd_addr_t'(2 * fld(armed, C_IDX) + 1)] = line_ptr(armed);
            armed++;
            arm_delay = int'($urandom_range(0, 5));
         end else begin
            arm_delay--;
         end
      end
      bd_rdata_i = bd_mem[bd_rd_addr];
   end

   // AXI read slave with random stalls
   always @(negedge clk_i) begin
      axi_addr_t base;
      base          = burst_addr & ~axi_addr_t'(3);
      axi_arready_i = !busy && ($urandom_range(0, 3) != 0);
      axi_rvalid_i  = busy && ($urandom_range(0, 3) != 0);
      axi_rlast_i   = busy && (beats_left == 1);
      axi_rdata_i   = {ext_mem[16'(base + 3)], ext_mem[16'(base + 2)],
                       ext_mem[16'(base + 1)], ext_mem[16'(base)]};
   end

   // Transmitter takes the frame after a random delay
   always @(negedge clk_i) begin
      if (!tx_ready_i && tx_released != frames_done) begin
         tx_ready_i  = 1'b1;
         tx_released = frames_done;
      end else if (tx_ready_i && send_o) begin
         if (tx_delay == 0) begin
            tx_ready_i = 1'b0;
            tx_delay   = int'($urandom_range(1, 8));
         end else begin
            tx_delay--;
         end
      end
   end

   // Monitor and checks
   always @(posedge clk_i) begin
      int         l;
      int         rem;
      int         blen;
      axi_addr_t  ptr;
      frame_len_t len;
      l   = (cur < nframes) ? cur : 0;
      ptr = line_ptr(l);
      len = line_len(l);
      if (!arst_i && !hold_phase) begin
         cycles++;
         if (cycles > limit) begin
            $display("Timeout: frames not finished within %0d cycles", limit);
            report_failure();
         end
      end
      if (hold_phase && axi_arvalid_o) begin
         $display("A read burst started while transmit was disabled");
         report_failure();
      end
      if (fb_wen_o)
         fb_mem[fb_addr_o] = fb_wdata_o;
      if (axi_arvalid_o && axi_arready_i) begin
         rem  = int'(len) - done_bytes;
         blen = (rem > AXI_MAX_BURST_LEN) ? AXI_MAX_BURST_LEN : rem;
         compare_addr(axi_araddr_o, ptr + axi_addr_t'(done_bytes), "burst address");
         compare_len(frame_len_t'(axi_arlen_o), frame_len_t'(blen - 1), "burst length");
         busy       = 1'b1;
         burst_addr = axi_araddr_o;
         beats_left = int'(axi_arlen_o) + 1;
         done_bytes = done_bytes + beats_left;
      end
      if (axi_rvalid_i && axi_rready_o) begin
         burst_addr = burst_addr + 1;
         beats_left--;
         if (beats_left == 0)
            busy = 1'b0;
      end
      if (send_o) begin
         compare_len(tx_nbytes_o, frame_len_t'(PRE_FRAME_LEN) + len, "tx_nbytes_o");
         compare_bit(crc_en_o, fld(l, C_CRC) != 0, "crc_en_o");
      end
      if (tx_irq_o && !bd_wen_o) begin
         $display("Interrupt raised outside a status write");
         report_failure();
      end
      if (bd_wen_o) begin
         if (cur >= nframes) begin
            $display("Status write after the last expected frame");
            report_failure();
         end
         compare_addr(axi_addr_t'(bd_waddr_o), axi_addr_t'(2 * fld(l, C_IDX)),
                      "status address");
         compare_word(bd_wdata_o, line_desc(l, 1'b0), "status word");
         compare_bit(tx_irq_o, fld(l, C_EXP) != 0, "tx_irq_o");
         compare_len(frame_len_t'(done_bytes), len, "bytes fetched");
         for (int k = 0; k < int'(len); k++)
            compare_byte(fb_mem[fb_addr_t'(PRE_FRAME_LEN + k)],
                         ext_mem[16'(ptr + axi_addr_t'(k))], "payload byte");
         wr_addr    = bd_waddr_o;
         wr_data    = bd_wdata_o;
         done_bytes = 0;
         cur++;
         frames_done++;
      end
   end

   initial begin
      int total;
      void'($urandom(32'hf439));
      total   = 0;
      nframes = 0;
      for (int i = 0; i < 128; i++)
         pat[i] = '1;
      $readmemh("dv/tx_dma_patterns.txt", pat);
      while (nframes < MAX_FRAMES && fld(nframes, C_IDX) !== '1) begin
         total = total + int'(line_len(nframes));
         nframes++;
      end
      limit = 200 + 20 * nframes + 4 * total;
      for (int a = 0; a < 65536; a++)
         ext_mem[a] = byte_t'($urandom);

      repeat (8) @(negedge clk_i);
      arst_i = 1'b0;

      // Transmit stays off for a while, descriptor 0 is already armed
      repeat (40) @(negedge clk_i);
      for (int a = 0; a < PREAMBLE_LEN; a++)
         compare_byte(fb_mem[fb_addr_t'(a)], PREAMBLE_BYTE, "preamble byte");
      compare_byte(fb_mem[fb_addr_t'(PREAMBLE_LEN)], SFD_BYTE, "SFD byte");
      hold_phase = 1'b0;
      tx_en_i    = 1'b1;

      wait (frames_done == nframes);
      repeat (4) @(negedge clk_i);
      $display("Everything OK");
      $finish;
   end

endmodule

/* dv/tx_dma_patterns.txt */
// One frame per line in ring service order, all hex
// idx len ptr irq wrap crc exp_irq
0 001 00001000 1 0 1 1
1 010 00002001 0 0 0 0
2 011 00003002 1 1 1 1
0 021 00004003 0 0 1 0
1 005 00005000 1 0 0 1
2 028 00006001 0 0 1 0
3 003 00007002 1 0 0 1
4 040 00008003 0 0 1 0
0 002 00009001 1 0 0 1

/* flist.f */
source/eth_dma_pkg.sv
source/tx_bd_fetch.sv
source/tx_burst_reader.sv
source/tx_bd_writeback.sv
source/eth_tx_dma.sv
dv/eth_tx_dma_sva.sv
dv/eth_tx_dma_tb.sv

/* source/eth_dma_pkg.sv */
package eth_dma_pkg;

   // Field widths of the descriptor format
   localparam int BD_WORD_W   = 32;
   localparam int BD_NUM_W    = 7;
   localparam int BD_ADDR_W   = BD_NUM_W + 1;
   localparam int AXI_ADDR_W  = 32;
   localparam int AXI_DATA_W  = 32;
   localparam int AXI_LEN_W   = 8;
   localparam int FRAME_LEN_W = 11;
   localparam int FB_ADDR_W   = 11;
   localparam int BYTE_W      = 8;

   // One descriptor-memory word (status or buffer pointer)
   typedef logic [BD_WORD_W-1:0] bd_word_t;

   // Ring index, 128 descriptors at most
   typedef logic [BD_NUM_W-1:0] bd_num_t;

   // Word address is {index, pointer select}
   typedef logic [BD_ADDR_W-1:0] bd_addr_t;

   typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
   typedef logic [AXI_DATA_W-1:0] axi_data_t;

   // AXI burst length, beats minus one
   typedef logic [AXI_LEN_W-1:0] axi_len_t;

   // Frame length or byte count
   typedef logic [FRAME_LEN_W-1:0] frame_len_t;

   typedef logic [FB_ADDR_W-1:0] fb_addr_t;
   typedef logic [BYTE_W-1:0]    byte_t;

   // Longest read burst, in byte beats
   localparam int AXI_MAX_BURST_LEN = 16;

   // Ethernet preamble and start-of-frame delimiter
   localparam int    PREAMBLE_LEN  = 7;
   localparam byte_t PREAMBLE_BYTE = 8'h55;
   localparam byte_t SFD_BYTE      = 8'hD5;

   // Payload starts right after preamble and SFD
   localparam int PRE_FRAME_LEN = PREAMBLE_LEN + 1;

   // Descriptor status word layout
   // Length sits in bits 26..16
   localparam int BD_LEN_LSB   = 16;
   localparam int BD_READY_BIT = 15;
   localparam int BD_IRQ_BIT   = 14;
   localparam int BD_WRAP_BIT  = 13;
   localparam int BD_CRC_BIT   = 11;

endpackage

/* source/eth_tx_dma.sv */
`timescale 1ns/1ps

module eth_tx_dma
   import eth_dma_pkg::*;
(
   input  logic       clk_i,
   input  logic       arst_i,
   input  logic       tx_en_i,
   input  bd_num_t    tx_bd_num_i,
   // Descriptor memory
   output bd_addr_t   bd_raddr_o,
   input  bd_word_t   bd_rdata_i,
   output logic       bd_wen_o,
   output bd_addr_t   bd_waddr_o,
   output bd_word_t   bd_wdata_o,
   // AXI read address and data
   output axi_addr_t  axi_araddr_o,
   output axi_len_t   axi_arlen_o,
   output logic       axi_arvalid_o,
   input  logic       axi_arready_i,
   input  axi_data_t  axi_rdata_i,
   input  logic       axi_rvalid_i,
   input  logic       axi_rlast_i,
   output logic       axi_rready_o,
   // Frame buffer
   output logic       fb_wen_o,
   output fb_addr_t   fb_addr_o,
   output byte_t      fb_wdata_o,
   // Transmitter
   input  logic       tx_ready_i,
   output logic       send_o,
   output frame_len_t tx_nbytes_o,
   output logic       crc_en_o,
   output logic       tx_irq_o
);

   logic      desc_valid;
   logic      desc_ready;
   bd_word_t  desc_word;
   axi_addr_t desc_ptr;
   bd_num_t   desc_num;
   logic      frame_valid;
   logic      frame_ready;
   bd_word_t  frame_word;
   bd_num_t   frame_num;
   logic      wb_done;

   tx_bd_fetch tx_bd_fetch_inst (
      .clk_i        (clk_i),
      .arst_i       (arst_i),
      .tx_en_i      (tx_en_i),
      .tx_bd_num_i  (tx_bd_num_i),
      .tx_ready_i   (tx_ready_i),
      .bd_raddr_o   (bd_raddr_o),
      .bd_rdata_i   (bd_rdata_i),
      .desc_valid_o (desc_valid),
      .desc_ready_i (desc_ready),
      .desc_word_o  (desc_word),
      .desc_ptr_o   (desc_ptr),
      .desc_num_o   (desc_num),
      .wb_done_i    (wb_done)
   );

   tx_burst_reader tx_burst_reader_inst (
      .clk_i         (clk_i),
      .arst_i        (arst_i),
      .desc_valid_i  (desc_valid),
      .desc_ready_o  (desc_ready),
      .desc_word_i   (desc_word),
      .desc_ptr_i    (desc_ptr),
      .desc_num_i    (desc_num),
      .axi_araddr_o  (axi_araddr_o),
      .axi_arlen_o   (axi_arlen_o),
      .axi_arvalid_o (axi_arvalid_o),
      .axi_arready_i (axi_arready_i),
      .axi_rdata_i   (axi_rdata_i),
      .axi_rvalid_i  (axi_rvalid_i),
      .axi_rlast_i   (axi_rlast_i),
      .axi_rready_o  (axi_rready_o),
      .fb_wen_o      (fb_wen_o),
      .fb_addr_o     (fb_addr_o),
      .fb_wdata_o    (fb_wdata_o),
      .frame_valid_o (frame_valid),
      .frame_ready_i (frame_ready),
      .frame_word_o  (frame_word),
      .frame_num_o   (frame_num)
   );

   tx_bd_writeback tx_bd_writeback_inst (
      .clk_i         (clk_i),
      .arst_i        (arst_i),
      .frame_valid_i (frame_valid),
      .frame_ready_o (frame_ready),
      .frame_word_i  (frame_word),
      .frame_num_i   (frame_num),
      .tx_ready_i    (tx_ready_i),
      .send_o        (send_o),
      .tx_nbytes_o   (tx_nbytes_o),
      .crc_en_o      (crc_en_o),
      .bd_wen_o      (bd_wen_o),
      .bd_waddr_o    (bd_waddr_o),
      .bd_wdata_o    (bd_wdata_o),
      .tx_irq_o      (tx_irq_o),
      .wb_done_o     (wb_done)
   );

endmodule

/* source/tx_bd_fetch.sv */
`timescale 1ns/1ps

module tx_bd_fetch
   import eth_dma_pkg::*;
(
   input  logic      clk_i,
   input  logic      arst_i,
   input  logic      tx_en_i,
   input  bd_num_t   tx_bd_num_i,
   input  logic      tx_ready_i,
   output bd_addr_t  bd_raddr_o,
   input  bd_word_t  bd_rdata_i,
   output logic      desc_valid_o,
   input  logic      desc_ready_i,
   output bd_word_t  desc_word_o,
   output axi_addr_t desc_ptr_o,
   output bd_num_t   desc_num_o,
   input  logic      wb_done_i
);

   typedef enum logic [2:0] {
      S_DESC_RD,
      S_DESC_CHK,
      S_PTR_LD,
      S_TX_WAIT,
      S_HANDOFF,
      S_WB_WAIT
   } state_t;

   state_t   state_q;
   bd_num_t  bd_num_q;
   bd_num_t  num_inc;
   bd_num_t  num_next;
   bd_word_t desc_word_q;
   bd_word_t ptr_q;
   bd_num_t  desc_num_q;

   // Pointer word is addressed while the status word is being checked
   assign bd_raddr_o = {bd_num_q, state_q == S_DESC_CHK};

   // Next ring position, wrap bit or ring size sends it back to 0
   assign num_inc  = bd_num_q + 7'd1;
   assign num_next = (desc_word_q[BD_WRAP_BIT] || num_inc >= tx_bd_num_i) ? '0 : num_inc;

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         state_q  <= S_DESC_RD;
         bd_num_q <= '0;
      end else begin
         case (state_q)
            S_DESC_RD: begin
               state_q <= S_DESC_CHK;
            end
            S_DESC_CHK: begin
               // Not owned by DMA yet, or TX off: poll again
               if (!bd_rdata_i[BD_READY_BIT] || !tx_en_i)
                  state_q <= S_DESC_RD;
               else
                  state_q <= S_PTR_LD;
            end
            S_PTR_LD: begin
               state_q <= S_TX_WAIT;
            end
            S_TX_WAIT: begin
               // Transmitter buffer must be free
               if (tx_ready_i)
                  state_q <= S_HANDOFF;
            end
            S_HANDOFF: begin
               if (desc_ready_i) begin
                  bd_num_q <= num_next;
                  state_q  <= S_WB_WAIT;
               end
            end
            S_WB_WAIT: begin
               // Status must land before the next read
               if (wb_done_i)
                  state_q <= S_DESC_RD;
            end
            default: state_q <= S_DESC_RD;
         endcase
      end
   end

   // Descriptor payload
   always_ff @(posedge clk_i) begin
      if (state_q == S_DESC_CHK) begin
         desc_word_q <= bd_rdata_i;
         desc_num_q  <= bd_num_q;
      end
      if (state_q == S_PTR_LD)
         ptr_q <= bd_rdata_i;
   end

   assign desc_valid_o = (state_q == S_HANDOFF);
   assign desc_word_o  = desc_word_q;
   assign desc_ptr_o   = axi_addr_t'(ptr_q);
   assign desc_num_o   = desc_num_q;

endmodule

/* source/tx_bd_writeback.sv */
`timescale 1ns/1ps

module tx_bd_writeback
   import eth_dma_pkg::*;
(
   input  logic       clk_i,
   input  logic       arst_i,
   input  logic       frame_valid_i,
   output logic       frame_ready_o,
   input  bd_word_t   frame_word_i,
   input  bd_num_t    frame_num_i,
   input  logic       tx_ready_i,
   output logic       send_o,
   output frame_len_t tx_nbytes_o,
   output logic       crc_en_o,
   output logic       bd_wen_o,
   output bd_addr_t   bd_waddr_o,
   output bd_word_t   bd_wdata_o,
   output logic       tx_irq_o,
   output logic       wb_done_o
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_SEND,
      S_WRITE
   } state_t;

   state_t     state_q;
   logic       send_q;
   bd_word_t   word_q;
   bd_num_t    num_q;
   frame_len_t nbytes_q;
   logic       crc_q;
   logic       accept;

   assign accept = (state_q == S_IDLE) && frame_valid_i;

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         state_q <= S_IDLE;
         send_q  <= 1'b0;
      end else begin
         case (state_q)
            S_IDLE: begin
               if (frame_valid_i) begin
                  send_q  <= 1'b1;
                  state_q <= S_SEND;
               end
            end
            S_SEND: begin
               // Transmitter took the frame
               if (!tx_ready_i) begin
                  send_q  <= 1'b0;
                  state_q <= S_WRITE;
               end
            end
            S_WRITE: state_q <= S_IDLE;
            default: state_q <= S_IDLE;
         endcase
      end
   end

   // Transmitter settings latched with the frame
   always_ff @(posedge clk_i) begin
      if (accept) begin
         word_q   <= frame_word_i;
         num_q    <= frame_num_i;
         nbytes_q <= frame_len_t'(PRE_FRAME_LEN) +
                     frame_len_t'(frame_word_i[BD_LEN_LSB +: $bits(frame_len_t)]);
         crc_q    <= frame_word_i[BD_CRC_BIT];
      end
   end

   assign frame_ready_o = (state_q == S_IDLE);
   assign send_o        = send_q;
   assign tx_nbytes_o   = nbytes_q;
   assign crc_en_o      = crc_q;

   // Status goes back to the status word with ownership returned to the CPU
   always_comb begin
      bd_wdata_o               = word_q;
      bd_wdata_o[BD_READY_BIT] = 1'b0;
   end

   assign bd_wen_o   = (state_q == S_WRITE);
   assign bd_waddr_o = {num_q, 1'b0};
   assign tx_irq_o   = (state_q == S_WRITE) && word_q[BD_IRQ_BIT];
   assign wb_done_o  = (state_q == S_WRITE);

endmodule

/* source/tx_burst_reader.sv */
`timescale 1ns/1ps

module tx_burst_reader
   import eth_dma_pkg::*;
(
   input  logic      clk_i,
   input  logic      arst_i,
   input  logic      desc_valid_i,
   output logic      desc_ready_o,
   input  bd_word_t  desc_word_i,
   input  axi_addr_t desc_ptr_i,
   input  bd_num_t   desc_num_i,
   output axi_addr_t axi_araddr_o,
   output axi_len_t  axi_arlen_o,
   output logic      axi_arvalid_o,
   input  logic      axi_arready_i,
   input  axi_data_t axi_rdata_i,
   input  logic      axi_rvalid_i,
   input  logic      axi_rlast_i,
   output logic      axi_rready_o,
   output logic      fb_wen_o,
   output fb_addr_t  fb_addr_o,
   output byte_t     fb_wdata_o,
   output logic      frame_valid_o,
   input  logic      frame_ready_i,
   output bd_word_t  frame_word_o,
   output bd_num_t   frame_num_o
);

   typedef enum logic [2:0] {
      S_FILL,
      S_IDLE,
      S_ADDR,
      S_DATA,
      S_DONE
   } state_t;

   state_t     state_q;
   frame_len_t byte_cnt_q;
   bd_word_t   word_q;
   axi_addr_t  ptr_q;
   bd_num_t    num_q;
   frame_len_t frame_len;
   frame_len_t remaining;
   frame_len_t burst_len;
   axi_addr_t  cur_addr;
   logic       beat;
   logic       fill_last;

   assign frame_len = frame_len_t'(word_q[BD_LEN_LSB +: $bits(frame_len_t)]);
   assign remaining = frame_len - byte_cnt_q;
   assign burst_len = (remaining > frame_len_t'(AXI_MAX_BURST_LEN)) ?
                      frame_len_t'(AXI_MAX_BURST_LEN) : remaining;

   // External address of the next byte
   assign cur_addr  = ptr_q + axi_addr_t'(byte_cnt_q);
   assign beat      = (state_q == S_DATA) && axi_rvalid_i;
   assign fill_last = (byte_cnt_q == frame_len_t'(PRE_FRAME_LEN - 1));

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         state_q    <= S_FILL;
         byte_cnt_q <= '0;
      end else begin
         case (state_q)
            S_FILL: begin
               byte_cnt_q <= byte_cnt_q + 11'd1;
               if (fill_last) begin
                  byte_cnt_q <= '0;
                  state_q    <= S_IDLE;
               end
            end
            S_IDLE: begin
               if (desc_valid_i) begin
                  byte_cnt_q <= '0;
                  state_q    <= S_ADDR;
               end
            end
            S_ADDR: begin
               // Whole frame fetched
               if (remaining == '0)
                  state_q <= S_DONE;
               else if (axi_arready_i)
                  state_q <= S_DATA;
            end
            S_DATA: begin
               if (axi_rvalid_i) begin
                  byte_cnt_q <= byte_cnt_q + 11'd1;
                  if (axi_rlast_i)
                     state_q <= S_ADDR;
               end
            end
            S_DONE: begin
               if (frame_ready_i)
                  state_q <= S_IDLE;
            end
            default: state_q <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == S_IDLE && desc_valid_i) begin
         word_q <= desc_word_i;
         ptr_q  <= desc_ptr_i;
         num_q  <= desc_num_i;
      end
   end

   assign desc_ready_o  = (state_q == S_IDLE);
   assign axi_araddr_o  = cur_addr;
   assign axi_arlen_o   = axi_len_t'(burst_len - 11'd1);
   assign axi_arvalid_o = (state_q == S_ADDR) && (remaining != '0);
   assign axi_rready_o  = (state_q == S_DATA);

   // Preamble fill writes from address 0, payload goes after the SFD
   always_comb begin
      fb_wen_o   = (state_q == S_FILL) || beat;
      fb_addr_o  = fb_addr_t'(frame_len_t'(PRE_FRAME_LEN) + byte_cnt_q);
      fb_wdata_o = axi_rdata_i[8*cur_addr[1:0] +: 8];
      if (state_q == S_FILL) begin
         fb_addr_o  = fb_addr_t'(byte_cnt_q);
         fb_wdata_o = (byte_cnt_q == frame_len_t'(PREAMBLE_LEN)) ? SFD_BYTE : PREAMBLE_BYTE;
      end
   end

   assign frame_valid_o = (state_q == S_DONE);
   assign frame_word_o  = word_q;
   assign frame_num_o   = num_q;

endmodule
